/* compile.f */
logic/fp_format_pkg.sv
logic/slice_ctrl_pkg.sv
logic/lane_bus_if.sv
logic/nan_canonicalizer.sv
logic/lane_slicer.sv
logic/lane_pipe.sv
logic/result_packer.sv
logic/fp_simd_slice.sv
verification/fp_simd_slice_tb.sv

/* logic/fp_format_pkg.sv */
// Only FP32 and FP16 are supported, and the lane layout assumes a 64-bit datapath
package fp_format_pkg;

  // --------------------------------------------------
  // Formats
  // --------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // --------------------------------------------------
  // Datapath and lanes
  // --------------------------------------------------
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned NUM_LANES  = 4;  // Lane count of the narrowest format
  localparam int unsigned LANE_WIDTH = 32; // One slot is as wide as the widest format

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [LANE_WIDTH-1:0] lane_data_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t;

  // Canonical quiet NaNs: positive sign, exponent all ones, only the quiet bit set
  localparam logic [FP32_WIDTH-1:0] CANON_NAN_FP32 = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] CANON_NAN_FP16 = 16'h7e00;

endpackage

/* logic/fp_simd_slice.sv */
// Latency is NUM_PIPE_REGS cycles without back-pressure; status carries only the invalid flag
`timescale 1ns/1ps

module fp_simd_slice (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Input side
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  input  fp_format_pkg::data_t       operand_a_i,
  input  fp_format_pkg::data_t       operand_b_i,
  input  fp_format_pkg::data_t       operand_c_i,
  input  slice_ctrl_pkg::operation_e op_i,
  input  fp_format_pkg::fp_format_e  fmt_i,
  input  logic                       vectorial_op_i,
  input  fp_format_pkg::lane_mask_t  simd_mask_i,
  // Output side
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output fp_format_pkg::data_t       result_o,
  output slice_ctrl_pkg::status_t    status_o,
  output logic                       busy_o
);

  lane_bus_if src_bus ();
  lane_bus_if dst_bus ();

  lane_slicer lane_slicer_inst (
    .operand_a_i    ( operand_a_i    ),
    .operand_b_i    ( operand_b_i    ),
    .operand_c_i    ( operand_c_i    ),
    .op_i           ( op_i           ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .src_bus        ( src_bus        )
  );

  lane_pipe lane_pipe_inst (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .flush_i ( flush_i ),
    .busy_o  ( busy_o  ),
    .in_bus  ( src_bus ),
    .out_bus ( dst_bus )
  );

  result_packer result_packer_inst (
    .in_bus      ( dst_bus     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    )
  );

endmodule

/* logic/lane_bus_if.sv */
// All lanes share one valid/ready pair, so a transfer always moves every lane together
`timescale 1ns/1ps

interface lane_bus_if;

  logic valid;
  logic ready; // Travels backwards
  fp_format_pkg::lane_data_t [fp_format_pkg::NUM_LANES-1:0] lane_data;
  logic [fp_format_pkg::NUM_LANES-1:0] lane_nv;   // Invalid flag per lane
  fp_format_pkg::lane_mask_t           lane_mask; // Active and unmasked lanes
  slice_ctrl_pkg::aux_t                aux;
  fp_format_pkg::data_t                target;    // Preloaded destination for CPK

  // Producing side of a stage boundary
  modport src (
    output valid, lane_data, lane_nv, lane_mask, aux, target,
    input  ready
  );

  // Consuming side of a stage boundary
  modport dst (
    input  valid, lane_data, lane_nv, lane_mask, aux, target,
    output ready
  );

endinterface

/* logic/lane_pipe.sv */
// Depth is fixed by NUM_PIPE_REGS; a flush drops every item in flight at the next edge
`timescale 1ns/1ps

module lane_pipe (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    flush_i,
  output logic    busy_o,
  lane_bus_if.dst in_bus,
  lane_bus_if.src out_bus
);

  localparam int unsigned DEPTH = slice_ctrl_pkg::NUM_PIPE_REGS;

  // Index i holds the item after i register stages
  logic                                                     valid_q  [0:DEPTH];
  fp_format_pkg::lane_data_t [fp_format_pkg::NUM_LANES-1:0] data_q   [0:DEPTH];
  logic [fp_format_pkg::NUM_LANES-1:0]                      nv_q     [0:DEPTH];
  fp_format_pkg::lane_mask_t                                mask_q   [0:DEPTH];
  slice_ctrl_pkg::aux_t                                     aux_q    [0:DEPTH];
  fp_format_pkg::data_t                                     target_q [0:DEPTH];
  logic [0:DEPTH]                                           ready;

  assign valid_q[0]  = in_bus.valid;
  assign data_q[0]   = in_bus.lane_data;
  assign nv_q[0]     = in_bus.lane_nv;
  assign mask_q[0]   = in_bus.lane_mask;
  assign aux_q[0]    = in_bus.aux;
  assign target_q[0] = in_bus.target;

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stages
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_ena  = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin // Payload only loads with a real item
        data_q[i+1]   <= data_q[i];
        nv_q[i+1]     <= nv_q[i];
        mask_q[i+1]   <= mask_q[i];
        aux_q[i+1]    <= aux_q[i];
        target_q[i+1] <= target_q[i];
      end
    end
  end

  assign ready[DEPTH] = out_bus.ready;
  assign in_bus.ready = ready[0];

  assign out_bus.valid     = valid_q[DEPTH];
  assign out_bus.lane_data = data_q[DEPTH];
  assign out_bus.lane_nv   = nv_q[DEPTH];
  assign out_bus.lane_mask = mask_q[DEPTH];
  assign out_bus.aux       = aux_q[DEPTH];
  assign out_bus.target    = target_q[DEPTH];

  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= DEPTH; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

/* logic/lane_slicer.sv */
// Boxing is checked on operand a of scalar moves only; CPK always uses lanes 0 and 1
`timescale 1ns/1ps

module lane_slicer (
  input  fp_format_pkg::data_t        operand_a_i,
  input  fp_format_pkg::data_t        operand_b_i,
  input  fp_format_pkg::data_t        operand_c_i,
  input  slice_ctrl_pkg::operation_e  op_i,
  input  fp_format_pkg::fp_format_e   fmt_i,
  input  logic                        vectorial_op_i,
  input  fp_format_pkg::lane_mask_t   simd_mask_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  lane_bus_if.src                     src_bus
);

  logic                      is_cpk;
  logic                      is_scalar;
  logic                      scalar_boxed;
  int unsigned               lane_count;
  fp_format_pkg::lane_mask_t lane_active;

  // --------------------------------------------------
  // Operation decode
  // --------------------------------------------------
  assign is_cpk    = (op_i == slice_ctrl_pkg::OP_CPKAB) || (op_i == slice_ctrl_pkg::OP_CPKCD);
  assign is_scalar = ~vectorial_op_i & ~is_cpk;

  assign lane_count = (fmt_i == fp_format_pkg::FMT_FP16) ? fp_format_pkg::NUM_LANES
                                                         : fp_format_pkg::NUM_LANES / 2;

  // Upper bits of a scalar must all be ones
  assign scalar_boxed = (fmt_i == fp_format_pkg::FMT_FP16)
                      ? &operand_a_i[fp_format_pkg::DATA_WIDTH-1:fp_format_pkg::FP16_WIDTH]
                      : &operand_a_i[fp_format_pkg::DATA_WIDTH-1:fp_format_pkg::FP32_WIDTH];

  // --------------------------------------------------
  // Lanes
  // --------------------------------------------------
  for (genvar lane = 0; lane < fp_format_pkg::NUM_LANES; lane++) begin : gen_lanes
    fp_format_pkg::lane_data_t lane_raw;
    logic                      lane_nv;

    always_comb begin
      if (fmt_i == fp_format_pkg::FMT_FP16) begin
        lane_raw = fp_format_pkg::lane_data_t'(operand_a_i >> (lane * fp_format_pkg::FP16_WIDTH));
      end else begin
        lane_raw = fp_format_pkg::lane_data_t'(operand_a_i >> (lane * fp_format_pkg::FP32_WIDTH));
      end
      if (is_cpk && lane == 1) begin
        lane_raw = operand_b_i[fp_format_pkg::LANE_WIDTH-1:0]; // Second pack source
      end
    end

    // Lane 0 always runs, CPK uses a pair, vectors fill the format
    if (lane == 0) begin : gen_base
      assign lane_active[lane] = 1'b1;
    end else begin : gen_upper
      assign lane_active[lane] = is_cpk ? (lane < 2) : (vectorial_op_i & (lane < lane_count));
    end

    nan_canonicalizer canon_inst (
      .value_i ( lane_raw                       ),
      .fmt_i   ( fmt_i                          ),
      .boxed_i ( ~is_scalar | scalar_boxed      ),
      .value_o ( src_bus.lane_data[lane]        ),
      .nv_o    ( lane_nv                        )
    );

    assign src_bus.lane_nv[lane] = lane_nv;
  end

  // --------------------------------------------------
  // Bus drive
  // --------------------------------------------------
  assign src_bus.valid     = in_valid_i;
  assign in_ready_o        = src_bus.ready;
  assign src_bus.lane_mask = simd_mask_i & lane_active;
  assign src_bus.aux       = {fmt_i, vectorial_op_i, op_i};
  assign src_bus.target    = operand_c_i; // Kept for CPK assembly
endmodule

/* logic/nan_canonicalizer.sv */
// FP16 values sit in the low 16 bits of the lane; upper lane bits pass through except for canonical NaN
`timescale 1ns/1ps

module nan_canonicalizer (
  input  fp_format_pkg::lane_data_t value_i,
  input  fp_format_pkg::fp_format_e fmt_i,
  input  logic                      boxed_i,
  output fp_format_pkg::lane_data_t value_o,
  output logic                      nv_o
);

  logic                      is_snan;
  fp_format_pkg::lane_data_t quiet_value;
  fp_format_pkg::lane_data_t canon_value;

  always_comb begin
    quiet_value = value_i;
    if (fmt_i == fp_format_pkg::FMT_FP16) begin
      // Exponent all ones, quiet bit clear, rest of mantissa nonzero
      is_snan        = (&value_i[14:10]) & ~value_i[9] & (|value_i[8:0]);
      quiet_value[9] = 1'b1;
      canon_value    = {{(fp_format_pkg::LANE_WIDTH - fp_format_pkg::FP16_WIDTH){1'b1}},
                        fp_format_pkg::CANON_NAN_FP16};
    end else begin
      is_snan         = (&value_i[30:23]) & ~value_i[22] & (|value_i[21:0]);
      quiet_value[22] = 1'b1;
      canon_value     = fp_format_pkg::CANON_NAN_FP32;
    end

    if (!boxed_i) begin
      value_o = canon_value; // Bad boxing is not an exception
      nv_o    = 1'b0;
    end else if (is_snan) begin
      value_o = quiet_value;
      nv_o    = 1'b1;
    end else begin
      value_o = value_i;
      nv_o    = 1'b0;
    end
  end

endmodule

/* logic/result_packer.sv */
// CPKCD only exists for FP16; with FP32 it returns the target unchanged
`timescale 1ns/1ps

module result_packer (
  lane_bus_if.dst                  in_bus,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output fp_format_pkg::data_t     result_o,
  output slice_ctrl_pkg::status_t  status_o
);

  fp_format_pkg::fp_format_e  fmt;
  logic                       is_vector;
  slice_ctrl_pkg::operation_e op;
  logic                       is_cpk;
  int unsigned                lane_count;
  fp_format_pkg::lane_mask_t  lane_active;
  fp_format_pkg::data_t       slice_result;

  // --------------------------------------------------
  // Aux decode
  // --------------------------------------------------
  assign fmt       = fp_format_pkg::fp_format_e'(in_bus.aux[3]);
  assign is_vector = in_bus.aux[2];
  assign op        = slice_ctrl_pkg::operation_e'(in_bus.aux[1:0]);
  assign is_cpk    = (op == slice_ctrl_pkg::OP_CPKAB) || (op == slice_ctrl_pkg::OP_CPKCD);

  assign lane_count = (fmt == fp_format_pkg::FMT_FP16) ? fp_format_pkg::NUM_LANES
                                                       : fp_format_pkg::NUM_LANES / 2;

  always_comb begin
    for (int i = 0; i < fp_format_pkg::NUM_LANES; i++) begin
      lane_active[i] = (i == 0) || (is_cpk ? (i < 2) : (is_vector && i < lane_count));
    end
  end

  // --------------------------------------------------
  // Lane placement, unused slots are NaN-boxed
  // --------------------------------------------------
  always_comb begin
    slice_result = '1;
    for (int i = 0; i < fp_format_pkg::NUM_LANES; i++) begin
      if (lane_active[i]) begin
        if (fmt == fp_format_pkg::FMT_FP16) begin
          slice_result[i*fp_format_pkg::FP16_WIDTH +: fp_format_pkg::FP16_WIDTH] =
              in_bus.lane_data[i][fp_format_pkg::FP16_WIDTH-1:0];
        end else if (i < fp_format_pkg::NUM_LANES / 2) begin
          slice_result[i*fp_format_pkg::FP32_WIDTH +: fp_format_pkg::FP32_WIDTH] =
              in_bus.lane_data[i][fp_format_pkg::FP32_WIDTH-1:0];
        end
      end
    end
  end

  // Cast-and-pack overwrites one pair of the preloaded target
  always_comb begin
    result_o = slice_result;
    if (op == slice_ctrl_pkg::OP_CPKAB) begin
      result_o = in_bus.target;
      if (fmt == fp_format_pkg::FMT_FP16) begin
        result_o[2*fp_format_pkg::FP16_WIDTH-1:0] = slice_result[2*fp_format_pkg::FP16_WIDTH-1:0];
      end else begin
        result_o[2*fp_format_pkg::FP32_WIDTH-1:0] = slice_result[2*fp_format_pkg::FP32_WIDTH-1:0];
      end
    end else if (op == slice_ctrl_pkg::OP_CPKCD) begin
      result_o = in_bus.target; // Upper pair is out of range for FP32
      if (fmt == fp_format_pkg::FMT_FP16) begin
        result_o[4*fp_format_pkg::FP16_WIDTH-1:2*fp_format_pkg::FP16_WIDTH] =
            slice_result[2*fp_format_pkg::FP16_WIDTH-1:0];
      end
    end
  end

  // Invalid from active lanes under the SIMD mask
  always_comb begin
    status_o = '0;
    status_o[slice_ctrl_pkg::STATUS_NV] = |(in_bus.lane_nv & in_bus.lane_mask);
  end

  assign out_valid_o  = in_bus.valid;
  assign in_bus.ready = out_ready_i;

endmodule

/* logic/slice_ctrl_pkg.sv */
// Aux layout is {format, vectorial, operation}; only the invalid status flag is ever raised
package slice_ctrl_pkg;

  // --------------------------------------------------
  // Operations
  // --------------------------------------------------
  typedef enum logic [1:0] {
    OP_MOVE  = 2'd0, // Plain move with NaN canonicalization
    OP_CPKAB = 2'd1, // Cast-and-pack into the lower pair
    OP_CPKCD = 2'd2  // Cast-and-pack into the upper pair
  } operation_e;

  // --------------------------------------------------
  // Status flags
  // --------------------------------------------------
  // Order is NV, DZ, OF, UF, NX from top to bottom
  typedef logic [4:0] status_t;

  localparam int unsigned STATUS_NV = 4;

  // --------------------------------------------------
  // Side information
  // --------------------------------------------------
  // Bit 3 is the format, bit 2 the vectorial flag, bits 1:0 the operation
  typedef logic [3:0] aux_t;

  // Register stages between input and output
  localparam int unsigned NUM_PIPE_REGS = 2;

endpackage

/* verification/fp_simd_slice_tb.sv */
// Results are checked in order at each output transfer; latency only while out_ready stays high
`timescale 1ns/1ps

module fp_simd_slice_tb;

  localparam int unsigned NUM_ITEMS    = 60;
  localparam int unsigned LIMIT_CYCLES = NUM_ITEMS * 12 + 100; // Worst case with random stalls

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic flush;
  logic out_valid;
  logic out_ready;
  logic busy;
  logic vec;
  logic fmt_pick;
  fp_format_pkg::data_t       op_a;
  fp_format_pkg::data_t       op_b;
  fp_format_pkg::data_t       op_c;
  fp_format_pkg::data_t       result;
  fp_format_pkg::fp_format_e  fmt_sel;
  fp_format_pkg::lane_mask_t  mask;
  slice_ctrl_pkg::operation_e op_sel;
  slice_ctrl_pkg::status_t    status;

  logic [68:0] exp_q[$];   // {status, result} per accepted item
  int unsigned acc_q[$];   // Cycle of acceptance
  bit          lat_q[$];   // Latency is fixed for this item
  int unsigned cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_start_errors;
  bit          fixed_ready;
  bit          rand_ready;
  string       cur_test;

  fp_simd_slice fp_simd_slice_inst (
    .clk_i          ( clk       ),
    .rst_i          ( rst       ),
    .in_valid_i     ( in_valid  ),
    .in_ready_o     ( in_ready  ),
    .flush_i        ( flush     ),
    .operand_a_i    ( op_a      ),
    .operand_b_i    ( op_b      ),
    .operand_c_i    ( op_c      ),
    .op_i           ( op_sel    ),
    .fmt_i          ( fmt_sel   ),
    .vectorial_op_i ( vec       ),
    .simd_mask_i    ( mask      ),
    .out_valid_o    ( out_valid ),
    .out_ready_i    ( out_ready ),
    .result_o       ( result    ),
    .status_o       ( status    ),
    .busy_o         ( busy      )
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (rand_ready) begin
      out_ready = $urandom_range(1, 0);
    end
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [68:0] model(input logic [1:0] op, input logic fmt,
      input logic vector, input logic [3:0] lane_mask, input logic [63:0] a, b, c);
    int unsigned w;
    int unsigned qbit;
    logic [63:0] res;
    logic [63:0] field;
    logic [63:0] pair;
    logic [31:0] v;
    logic [31:0] emask;
    logic        boxed;
    logic        active;
    logic        nv;
    w     = fmt ? 16 : 32;
    qbit  = fmt ? 9 : 22;                        // Quiet bit
    emask = fmt ? 32'h7c00 : 32'h7f80_0000;
    pair  = fmt ? 64'hffff_ffff : '1;
    boxed = (op != 0) || vector || ((a | ((64'd1 << w) - 1)) == '1);
    res   = '1;
    nv    = 1'b0;
    for (int i = 0; i < 64 / w; i++) begin
      active = (i == 0) || ((op != 0) ? (i < 2) : vector);
      v      = (op != 0 && i == 1) ? b[31:0] : 32'(a >> (i * w));
      field  = ((64'd1 << w) - 1) << (i * w);
      if (!boxed) begin
        v = fmt ? 32'h7e00 : 32'h7fc0_0000;
      end else if ((v & emask) == emask && !v[qbit] && (v & ((32'd1 << qbit) - 1)) != 0) begin
        v[qbit] = 1'b1;
        nv      = nv | (active & lane_mask[i]);
      end
      if (active) begin
        res = (res & ~field) | ((64'(v) << (i * w)) & field);
      end
    end
    if (op == 1) begin
      res = (c & ~pair) | (res & pair);
    end else if (op == 2) begin
      res = fmt ? ((c & ~(pair << 32)) | ((res & pair) << 32)) : c; // No upper pair in FP32
    end
    return {nv, 4'b0000, res};
  endfunction

  // --------------------------------------------------
  // Output checks
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rst && out_valid) begin
      checks++;
      assert (busy) else begin
        $display("error %s busy expected 1 actual %b", cur_test, busy);
        errors++;
      end
    end
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output in %s arrived with no item in flight", cur_test);
        errors++;
      end else begin
        checks++;
        assert ({status, result} == exp_q[0]) else begin
          $display("error %s expected %h actual %h", cur_test, exp_q[0], {status, result});
          errors++;
        end
        assert (!lat_q[0] || cycle - acc_q[0] == slice_ctrl_pkg::NUM_PIPE_REGS) else begin
          $display("error %s latency expected %0d actual %0d", cur_test,
                   slice_ctrl_pkg::NUM_PIPE_REGS, cycle - acc_q[0]);
          errors++;
        end
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
        void'(lat_q.pop_front());
      end
    end
  end

  task automatic check_idle();
    repeat (3) begin
      @(posedge clk);
      checks++;
      assert (!out_valid && !busy) else begin
        $display("error %s expected valid/busy 00 actual %b%b", cur_test, out_valid, busy);
        errors++;
      end
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic send(input logic [1:0] op, input logic fmt, input logic vector,
      input logic [3:0] lane_mask, input logic [63:0] a, b, c);
    @(negedge clk);
    in_valid = 1'b1;
    op_sel   = slice_ctrl_pkg::operation_e'(op);
    fmt_sel  = fp_format_pkg::fp_format_e'(fmt);
    vec      = vector;
    mask     = lane_mask;
    op_a     = a;
    op_b     = b;
    op_c     = c;
    forever begin
      @(posedge clk);
      if (in_ready) begin
        break;
      end
    end
    exp_q.push_back(model(op, fmt, vector, lane_mask, a, b, c));
    acc_q.push_back(cycle);
    lat_q.push_back(fixed_ready);
  endtask

  task automatic start_test(input string name);
    @(negedge clk);
    in_valid          = 1'b0;
    cur_test          = name;
    test_start_errors = errors;
  endtask

  task automatic close_test();
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    tests++;
    $display("Test %s finished with %0d errors", cur_test, errors - test_start_errors);
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [15:0] half_lane();
    if ($urandom_range(1, 0)) begin
      return 16'h7c00 | 16'($urandom_range(511, 1)) | (16'($urandom_range(1, 0)) << 15);
    end
    return 16'($urandom);
  endfunction

  initial begin
    void'($urandom(32'h0048a7aa));
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    flush = 1'b0;
    out_ready = 1'b1;
    op_a = '0;
    op_b = '0;
    op_c = '0;
    op_sel = slice_ctrl_pkg::OP_MOVE;
    fmt_sel = fp_format_pkg::FMT_FP32;
    vec = 1'b0;
    mask = '0;
    fixed_ready = 1'b1;
    rand_ready = 1'b0;
    cur_test = "reset";
    repeat (4) @(negedge clk);
    rst = 1'b0;

    start_test("reset");
    check_idle();
    close_test();

    start_test("scalar_move");
    repeat (8) begin
      fmt_pick = $urandom_range(1, 0);
      send(0, fmt_pick, 0, 4'($urandom),
           rand64() | (fmt_pick ? 64'hffff_ffff_ffff_0000 : 64'hffff_ffff_0000_0000), 0, 0);
    end
    close_test();

    start_test("vector_quiet");
    repeat (8) begin
      send(0, 1, 1, 4'($urandom), {half_lane(), half_lane(), half_lane(), half_lane()}, 0, 0);
    end
    close_test();

    start_test("unboxed_scalar");
    repeat (4) begin
      send(0, $urandom_range(1, 0), 0, 4'hf, rand64() & 64'h7fff_ffff_ffff_ffff, 0, 0);
    end
    close_test();

    start_test("cast_pack");
    repeat (2) begin
      send(1, 0, $urandom_range(1, 0), 4'hf, rand64(), rand64(), rand64());
      send(1, 1, $urandom_range(1, 0), 4'hf, rand64(), rand64(), rand64());
      send(2, 1, $urandom_range(1, 0), 4'hf, rand64(), rand64(), rand64());
    end
    close_test();

    start_test("stall");
    fixed_ready = 1'b0;
    rand_ready  = 1'b1;
    repeat (20) begin
      send($urandom_range(2, 0), $urandom_range(1, 0), $urandom_range(1, 0), 4'($urandom),
           rand64(), rand64(), rand64());
    end
    close_test();
    rand_ready = 1'b0;

    start_test("flush");
    out_ready = 1'b0;
    send(0, 1, 1, 4'hf, rand64(), 0, 0);
    send(1, 0, 0, 4'hf, rand64(), rand64(), rand64());
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    exp_q.delete();                              // Both items are dropped
    acc_q.delete();
    lat_q.delete();
    check_idle();
    @(negedge clk);
    out_ready   = 1'b1;
    fixed_ready = 1'b1;
    send(0, 0, 1, 4'hf, rand64(), 0, 0);
    close_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(LIMIT_CYCLES * 100);
    $display("Timeout after %0d cycles with %0d results outstanding", LIMIT_CYCLES, exp_q.size());
    $display("Errors found");
    $finish;
  end

endmodule
